/* design/alu_settings.svh */
// ALU build settings
// widths shared by the slices, the 16-bit ALU and the APB register file
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// width of the data path, numbered big-endian with bit 0 the most significant
`define ALU_WIDTH 16

// bits handled by one 181-style slice
`define SLICE_WIDTH 4

// address bits decoded by the APB register file
`define APB_AW 4

`endif

/* design/alu_pkg.sv */
// ALU package
// operation codes as written to the OP register, and the select lines
// that every 181-style slice takes from the operation decoder
`default_nettype none

package alu_pkg;

	// operation codes, where arithmetic ones add the carry-in bit
	typedef enum logic [3:0] {
		add    = 4'd0,
		sub    = 4'd1,
		or_op  = 4'd2,
		orn    = 4'd3,
		and_op = 4'd4,
		// not-A and B
		nand_a = 4'd5,
		// A and not-B
		andn   = 4'd6,
		xor_op = 4'd7,
		// arithmetic A plus carry
		pass_a = 4'd8,
		// logic A, no carry involved
		ones_a = 4'd9,
		pass_b = 4'd10,
		dec    = 4'd11,
		not_a  = 4'd12,
		// A plus A
		dbl    = 4'd13
	} alu_op_e;

	// s is the slice select code, saryt picks arithmetic when set
	typedef struct packed {
		logic [3:0] s;
		logic       saryt;
	} alu_sel_t;

endpackage

`default_nettype wire

/* design/apb_pkg.sv */
// APB register map
// addresses of the ALU registers and the bit layout of the result register
`default_nettype none

`include "alu_settings.svh"

package apb_pkg;

	// OP holds the operation code in bits 3:0 and the carry-in in bit 4
	typedef enum logic [`APB_AW-1:0] {
		reg_a   = 0,
		reg_ac  = 4,
		reg_op  = 8,
		reg_res = 12
	} reg_addr_e;

	// the sum sits in the low half with f[0] at bit 15
	localparam int RES_F = 0;
	// flags above the sum, all active high in the register
	localparam int RES_J = 16;
	localparam int RES_C = 17;
	localparam int RES_Z = 18;

endpackage

`default_nettype wire

/* design/alu_if.sv */
// ALU interfaces
// alu_ctl_if carries operands, select lines and carry-in from the register file,
// alu_res_if carries the sum and the flags back in their board polarities
`default_nettype none

`include "alu_settings.svh"

interface alu_ctl_if;
	import alu_pkg::*;

	logic [0:`ALU_WIDTH-1] a;
	logic [0:`ALU_WIDTH-1] ac;
	alu_sel_t              sel;
	// carry into the least significant slice, active low
	logic                  p16_;

	modport regs (output a, ac, sel, p16_);
	modport alu (input a, ac, sel, p16_);
endinterface

interface alu_res_if;
	logic [0:`ALU_WIDTH-1] f;
	logic                  j;
	// carry out of the most significant slice, low means a carry
	logic                  carry_;
	// low when the sum is zero
	logic                  zsum_;

	modport alu (output f, j, carry_, zsum_);
	modport regs (input f, j, carry_, zsum_);
endinterface

`default_nettype wire

/* design/alu181.sv */
// 181-style arithmetic-logic slice
// one of sixteen logic or sixteen arithmetic functions of a and b picked by s,
// with m high for logic, and active-low carry, propagate and generate pins
// for a look-ahead unit; eq is high when the slice output is all ones
`default_nettype none

`include "alu_settings.svh"

module alu181 (
	input  logic [`SLICE_WIDTH-1:0] a,
	input  logic [`SLICE_WIDTH-1:0] b,
	input  logic [3:0]              s,
	input  logic                    m,
	input  logic                    cn_,
	output logic [`SLICE_WIDTH-1:0] f,
	output logic                    eq,
	output logic                    x,
	output logic                    y,
	output logic                    cn4_
);

	logic [`SLICE_WIDTH-1:0] p;
	logic [`SLICE_WIDTH-1:0] g;
	logic [`SLICE_WIDTH-1:0] h;
	logic [`SLICE_WIDTH:0]   c;
	logic                    gg;

	// per-bit propagate and generate terms, chosen by the select code
	// arithmetic mode then forms p plus g plus carry, and g never exceeds p
	assign p = a | (b & {`SLICE_WIDTH{s[0]}}) | (~b & {`SLICE_WIDTH{s[1]}});
	assign g = (a & ~b & {`SLICE_WIDTH{s[2]}}) | (a & b & {`SLICE_WIDTH{s[3]}});
	assign h = p ^ g;

	// internal carries run from the active-low carry-in upwards
	always_comb begin
		c[0] = ~cn_;
		gg = 1'b0;
		for (int i = 0; i < `SLICE_WIDTH; i++) begin
			c[i+1] = g[i] | (p[i] & c[i]);
			gg = g[i] | (p[i] & gg);
		end
	end

	// in logic mode the carries are masked and the output is the inverted half sum
	assign f = h ^ (c[`SLICE_WIDTH-1:0] | {`SLICE_WIDTH{m}});

	// comparator pin, open collector on the board and wired together outside
	assign eq = &f;

	// group terms for the look-ahead unit, both active low
	assign x = ~(&p);
	assign y = ~gg;

	assign cn4_ = ~c[`SLICE_WIDTH];

endmodule

`default_nettype wire

/* design/carry182.sv */
// 182-style look-ahead carry unit
// forms the carries into slices 1, 2 and 3 in parallel from the active-low
// slice generate and propagate pins, plus the group propagate and generate
`default_nettype none

module carry182 (
	input  logic [3:0] y,
	input  logic [3:0] x,
	input  logic       cn_,
	output logic       cnx_,
	output logic       cny_,
	output logic       cnz_,
	output logic       ox,
	output logic       oy
);

	logic [3:0] g;
	logic [3:0] p;
	logic       c0;

	// work in active-high terms inside, index 0 is the least significant slice
	assign g = ~y;
	assign p = ~x;
	assign c0 = ~cn_;

	// each carry is a flat sum of products, no term waits on another carry
	assign cnx_ = ~(g[0] | (p[0] & c0));
	assign cny_ = ~(g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0));
	assign cnz_ = ~(g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & c0));

	// group outputs for a second level of look-ahead
	assign ox = ~(&p);
	assign oy = ~(g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]));

endmodule

`default_nettype wire

/* design/alu.sv */
// 16-bit ALU
// four 181-style slices and one 182-style carry unit side by side, all slices
// on one select code; also forms the all-ones flag and the zero detector
`default_nettype none

`include "alu_settings.svh"

module alu (
	alu_ctl_if.alu ctl,
	alu_res_if.alu res
);

	localparam int SLICES = `ALU_WIDTH / `SLICE_WIDTH;

	// slice pins, index 0 is the least significant slice at bits 12..15
	wire [0:`ALU_WIDTH-1]   f;
	wire [SLICES-1:0]       eq;
	wire [SLICES-1:0]       x_;
	wire [SLICES-1:0]       y_;
	wire [SLICES-1:0]       cn_;
	wire [SLICES-1:0]       cn4_;
	wire [0:`ALU_WIDTH/2-1] zpair_;
	logic                   m;

	// the slices take mode high for logic, the select lines carry it inverted
	assign m = ~ctl.sel.saryt;

	// lowest slice sees the external carry-in, the others get look-ahead carries
	assign cn_[0] = ctl.p16_;

	for (genvar k = 0; k < SLICES; k++) begin : g_slice
		localparam int LO = `ALU_WIDTH - (k + 1) * `SLICE_WIDTH;

		alu181 slice (
			.a   (ctl.a[LO +: `SLICE_WIDTH]),
			.b   (ctl.ac[LO +: `SLICE_WIDTH]),
			.s   (ctl.sel.s),
			.m   (m),
			.cn_ (cn_[k]),
			.f   (f[LO +: `SLICE_WIDTH]),
			.eq  (eq[k]),
			.x   (x_[k]),
			.y   (y_[k]),
			.cn4_(cn4_[k])
		);
	end

	// group propagate and generate stay open, there is no second level
	carry182 carry (
		.y   (y_),
		.x   (x_),
		.cn_ (ctl.p16_),
		.cnx_(cn_[1]),
		.cny_(cn_[2]),
		.cnz_(cn_[3]),
		.ox  (),
		.oy  ()
	);

	// zero detector as on the board, NOR pairs then one inverted AND
	for (genvar z = 0; z < `ALU_WIDTH / 2; z++) begin : g_zero
		assign zpair_[z] = ~(f[2*z] | f[2*z+1]);
	end

	assign res.zsum_ = ~(&zpair_);
	// wired AND of the comparator pins
	assign res.j = &eq;
	// only the most significant slice ripples its carry out
	assign res.carry_ = cn4_[SLICES-1];
	assign res.f = f;

endmodule

`default_nettype wire

/* design/alu_regs.sv */
// ALU register file on APB
// holds the A, AC and OP registers, decodes the op code into slice select
// lines and the carry-in, and packs sum and flags into the RES register
`default_nettype none

`include "alu_settings.svh"

module alu_regs (
	input  logic               pclk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	alu_ctl_if.regs            ctl,
	alu_res_if.regs            res
);
	import alu_pkg::*;
	import apb_pkg::*;

	logic [0:`ALU_WIDTH-1] a_q;
	logic [0:`ALU_WIDTH-1] ac_q;
	logic [3:0]            op_q;
	logic                  cin_q;
	logic                  access;
	logic                  mapped;
	logic                  writable;
	logic [31:0]           res_word;
	alu_sel_t              sel;

	// the access phase of a transfer never sees a wait state
	assign access = psel & penable;
	assign pready = 1'b1;

	assign mapped = paddr inside {reg_a, reg_ac, reg_op, reg_res};
	assign writable = paddr inside {reg_a, reg_ac, reg_op};

	// a write to RES or any access outside the map is refused
	assign pslverr = access & (pwrite ? ~writable : ~mapped);

	// writes land on the edge that closes the access phase
	always_ff @(posedge pclk) begin
		if (rst) begin
			a_q <= '0;
			ac_q <= '0;
			op_q <= '0;
			cin_q <= 1'b0;
		end else if (access && pwrite) begin
			case (paddr)
				reg_a:  a_q <= pwdata[`ALU_WIDTH-1:0];
				reg_ac: ac_q <= pwdata[`ALU_WIDTH-1:0];
				reg_op: begin
					op_q <= pwdata[3:0];
					cin_q <= pwdata[4];
				end
				default: ;
			endcase
		end
	end

	// slice function table of the board where codes 14 and 15 fall back to arithmetic A
	always_comb begin
		case (alu_op_e'(op_q))
			add:     sel = '{s: 4'b1001, saryt: 1'b1};
			sub:     sel = '{s: 4'b0110, saryt: 1'b1};
			or_op:   sel = '{s: 4'b1110, saryt: 1'b0};
			orn:     sel = '{s: 4'b1101, saryt: 1'b0};
			and_op:  sel = '{s: 4'b1011, saryt: 1'b0};
			nand_a:  sel = '{s: 4'b0010, saryt: 1'b0};
			andn:    sel = '{s: 4'b0111, saryt: 1'b0};
			xor_op:  sel = '{s: 4'b0110, saryt: 1'b0};
			pass_a:  sel = '{s: 4'b0000, saryt: 1'b1};
			ones_a:  sel = '{s: 4'b1111, saryt: 1'b0};
			pass_b:  sel = '{s: 4'b1010, saryt: 1'b0};
			dec:     sel = '{s: 4'b1111, saryt: 1'b1};
			not_a:   sel = '{s: 4'b0000, saryt: 1'b0};
			dbl:     sel = '{s: 4'b1100, saryt: 1'b1};
			default: sel = '{s: 4'b0000, saryt: 1'b1};
		endcase
	end

	assign ctl.a = a_q;
	assign ctl.ac = ac_q;
	assign ctl.sel = sel;
	// the slices want the carry-in active low
	assign ctl.p16_ = ~cin_q;

	// carry and zero come back active low and are turned around for software
	always_comb begin
		res_word = '0;
		res_word[RES_F +: `ALU_WIDTH] = res.f;
		res_word[RES_J] = res.j;
		res_word[RES_C] = ~res.carry_;
		res_word[RES_Z] = ~res.zsum_;
	end

	// read data follows the address and RES always shows the live ALU output
	always_comb begin
		prdata = '0;
		case (paddr)
			reg_a:   prdata[`ALU_WIDTH-1:0] = a_q;
			reg_ac:  prdata[`ALU_WIDTH-1:0] = ac_q;
			reg_op:  prdata[4:0] = {cin_q, op_q};
			reg_res: prdata = res_word;
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/alu_top.sv */
// ALU top level
// APB register file in front of the 16-bit slice ALU, joined by the
// control and result interfaces, with plain APB ports outside
`default_nettype none

`include "alu_settings.svh"

module alu_top (
	input  logic               pclk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr
);

	alu_ctl_if ctl_if ();
	alu_res_if res_if ();

	alu_regs alu_regs_inst (
		.pclk   (pclk),
		.rst    (rst),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr),
		.ctl    (ctl_if.regs),
		.res    (res_if.regs)
	);

	// purely combinational, the result is ready in the same cycle
	alu alu_inst (
		.ctl(ctl_if.alu),
		.res(res_if.alu)
	);

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// testbench clock and reset
// free-running pclk, with rst held high over the first three rising edges
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, like every other DUT input
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* tests/alu_tb.sv */
// ALU testbench
// drives the APB register file with random operands and op codes, compares
// RES against a reference model, and bounds the run with a watchdog
`default_nettype none

`include "alu_settings.svh"

module alu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import alu_pkg::*;
	import apb_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_READBACK = 8;
	localparam int N_ARITH = 300;
	localparam int N_LOGIC = 300;
	// each ALU case takes three writes and one read, and each transfer takes two cycles
	localparam int TRANSFERS = 4 + 6 * N_READBACK + 4 * (N_ARITH + 4 + N_LOGIC) + 9;
	localparam int TIMEOUT_NS = (2 * TRANSFERS + 3 + 200) * CLK_PERIOD;

	logic               pclk;
	logic               rst;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [31:0]        pwdata;
	logic [31:0]        prdata;
	logic               pready;
	logic               pslverr;
	integer             seed = 32'hf8ae;
	int                 errors = 0;
	int                 checks = 0;
	int                 tests_ok = 0;
	int                 tests_bad = 0;

	tb_clock #(.PERIOD(CLK_PERIOD)) clock_inst (.clk(pclk), .rst(rst));

	alu_top alu_top_inst (
		.pclk   (pclk),
		.rst    (rst),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	task automatic check(input string what, input logic [31:0] observed,
		input logic [31:0] expected);
		checks++;
		if (observed !== expected) begin
			errors++;
			$display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, observed, expected);
		end
	endtask

	// one APB transfer, setup then access, sampled in the low half of the access cycle
	task automatic transfer(input logic wr, input logic [`APB_AW-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge pclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge pclk);
		penable = 1'b1;
		#1;
		check("pready in access phase", {31'b0, pready}, 32'd1);
		rdata = prdata;
		err = pslverr;
		// a write lands on this edge
		@(posedge pclk);
	endtask

	function automatic logic is_arith(input alu_op_e op);
		return op inside {add, sub, pass_a, dec, dbl};
	endfunction

	// the arithmetic codes come first and the nine logic ones after them
	function automatic alu_op_e pick_op(input logic arith, input int k);
		if (arith) begin
			case (k % 5)
				0: return add;
				1: return sub;
				2: return pass_a;
				3: return dec;
				default: return dbl;
			endcase
		end
		case (k % 9)
			0: return or_op;
			1: return orn;
			2: return and_op;
			3: return nand_a;
			4: return andn;
			5: return xor_op;
			6: return ones_a;
			7: return pass_b;
			default: return not_a;
		endcase
	endfunction

	// expected RES word with the flags active high
	function automatic logic [31:0] expected_res(input logic [15:0] a, input logic [15:0] ac,
		input alu_op_e op, input logic cin);
		logic [16:0] sum;
		logic [15:0] x;
		logic [15:0] f;
		logic [31:0] w;
		// second addend of the arithmetic codes
		case (op)
			add: x = ac;
			sub: x = ~ac;
			dec: x = 16'hffff;
			dbl: x = a;
			default: x = 16'h0000;
		endcase
		sum = {1'b0, a} + {1'b0, x} + {16'h0000, cin};
		case (op)
			or_op: f = a | ac;
			orn: f = a | ~ac;
			and_op: f = a & ac;
			nand_a: f = ~a & ac;
			andn: f = a & ~ac;
			xor_op: f = a ^ ac;
			ones_a: f = a;
			pass_b: f = ac;
			not_a: f = ~a;
			default: f = sum[15:0];
		endcase
		w = '0;
		w[RES_F +: `ALU_WIDTH] = f;
		w[RES_J] = &f;
		w[RES_C] = is_arith(op) ? sum[16] : 1'b0;
		w[RES_Z] = (f == '0);
		return w;
	endfunction

	task automatic run_case(input alu_op_e op, input logic [15:0] a, input logic [15:0] ac,
		input logic cin);
		logic [31:0] rdata;
		logic        err;
		logic [31:0] mask;
		// logic codes leave the carry undefined
		mask = is_arith(op) ? 32'hffff_ffff : ~(32'd1 << RES_C);
		transfer(1'b1, reg_a, {16'h0000, a}, rdata, err);
		transfer(1'b1, reg_ac, {16'h0000, ac}, rdata, err);
		transfer(1'b1, reg_op, {27'h0, cin, op}, rdata, err);
		transfer(1'b0, reg_res, 32'h0, rdata, err);
		check($sformatf("%s a=%h ac=%h cin=%b", op.name(), a, ac, cin), rdata & mask,
			expected_res(a, ac, op, cin) & mask);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d mismatches", name, errors - errors_before);
		end
	endtask

	initial begin
		logic [31:0]        rnd;
		logic [31:0]        rnd2;
		logic [31:0]        rdata;
		logic [31:0]        keep;
		logic [`APB_AW-1:0] addr;
		logic               err;
		int                 first;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		@(negedge rst);

		// registers clear, so RES shows 0 plus 0 under add
		first = errors;
		transfer(1'b0, reg_a, 32'h0, rdata, err);
		check("A after reset", rdata, 32'h0);
		transfer(1'b0, reg_ac, 32'h0, rdata, err);
		check("AC after reset", rdata, 32'h0);
		transfer(1'b0, reg_op, 32'h0, rdata, err);
		check("OP after reset", rdata, 32'h0);
		transfer(1'b0, reg_res, 32'h0, rdata, err);
		check("RES after reset", rdata, expected_res(16'h0, 16'h0, add, 1'b0));
		check("pslverr after reset", {31'b0, err}, 32'd0);
		report_test("reset", first);

		// full random words go in and only the implemented bits may come back
		first = errors;
		for (int i = 0; i < N_READBACK; i++) begin
			for (int j = 0; j < 3; j++) begin
				addr = (j == 0) ? reg_a : (j == 1) ? reg_ac : reg_op;
				keep = (j == 2) ? 32'h0000_001f : 32'h0000_ffff;
				rnd = $random(seed);
				transfer(1'b1, addr, rnd, rdata, err);
				transfer(1'b0, addr, 32'h0, rdata, err);
				check($sformatf("read-back at %0d", addr), rdata, rnd & keep);
				check("read-back pslverr", {31'b0, err}, 32'd0);
			end
		end
		report_test("read-back", first);

		// carry out of the top slice and a borrow-free subtract of equal values
		first = errors;
		run_case(add, 16'hffff, 16'h0001, 1'b0);
		run_case(add, 16'hffff, 16'h0000, 1'b1);
		run_case(sub, 16'h1234, 16'h1234, 1'b1);
		run_case(dec, 16'h0000, 16'h0000, 1'b0);
		for (int i = 0; i < N_ARITH; i++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			run_case(pick_op(1'b1, int'(rnd2[15:0])), rnd[15:0], rnd[31:16], rnd2[16]);
		end
		report_test("arithmetic", first);

		first = errors;
		for (int i = 0; i < N_LOGIC; i++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			run_case(pick_op(1'b0, int'(rnd2[15:0])), rnd[15:0], rnd[31:16], rnd2[16]);
		end
		report_test("logic", first);

		// refused accesses must leave the registers as written
		first = errors;
		transfer(1'b1, reg_a, 32'h0000_5a5a, rdata, err);
		transfer(1'b1, reg_ac, 32'h0000_c3c3, rdata, err);
		transfer(1'b1, reg_op, 32'h0000_0017, rdata, err);
		transfer(1'b1, reg_res, 32'hffff_ffff, rdata, err);
		check("pslverr on RES write", {31'b0, err}, 32'd1);
		transfer(1'b1, 4'h6, 32'hffff_ffff, rdata, err);
		check("pslverr on unmapped write", {31'b0, err}, 32'd1);
		transfer(1'b0, 4'hd, 32'h0, rdata, err);
		check("pslverr on unmapped read", {31'b0, err}, 32'd1);
		transfer(1'b0, reg_a, 32'h0, rdata, err);
		check("A after refused writes", rdata, 32'h0000_5a5a);
		transfer(1'b0, reg_ac, 32'h0, rdata, err);
		check("AC after refused writes", rdata, 32'h0000_c3c3);
		transfer(1'b0, reg_op, 32'h0, rdata, err);
		check("OP after refused writes", rdata, 32'h0000_0017);
		check("pslverr on good read", {31'b0, err}, 32'd0);
		report_test("error response", first);

		@(negedge pclk);
		psel = 1'b0;
		penable = 1'b0;
		$display("tests: %0d ok, %0d bad; checks: %0d, mismatches: %0d",
			tests_ok, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// bound on the whole run worked out from the number of transfers above
	initial begin
		#(TIMEOUT_NS);
		$display("simulation timed out after %0d ns before all transfers finished", TIMEOUT_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/alu_pkg.sv
design/apb_pkg.sv
design/alu_if.sv
design/alu181.sv
design/carry182.sv
design/alu.sv
design/alu_regs.sv
design/alu_top.sv
tests/tb_clock.sv
tests/alu_tb.sv

/* run.sh */
#!/bin/sh
# compiles the ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f files.f --top-module alu_tb -Mdir "$BUILD_DIR" -o alu_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/alu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0
